//--- include/dualIssue_macros.svh
`ifndef DUALISSUE_MACROS_SVH
`define DUALISSUE_MACROS_SVH

// datapath and register number widths
`define DATA_W      32
`define REG_ADDR_W  5

// fetch side
`define RESET_PC    32'hbfc00000  // boot vector
`define FETCH_STEP  8             // one pair of words per fetch

// mips instruction fields
`define OP_MSB      31
`define OP_LSB      26
`define RS_MSB      25
`define RS_LSB      21
`define RT_MSB      20
`define RT_LSB      16
`define RD_MSB      15
`define RD_LSB      11

`define IMM_W       16  // low half of I-type words

`endif

//--- verilog/dualIssuePkg.sv
`default_nettype none

package dualIssuePkg;

    // alu operations, shared by the decoder and both lanes
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,  // signed compare
        ALU_LUI = 3'd6
    } aluOpT;

    // where a decode operand comes from
    typedef enum logic [2:0] {
        FWD_RF = 3'd0,  // register file, nothing newer in flight
        FWD_E1 = 3'd1,
        FWD_E2 = 3'd2,
        FWD_W1 = 3'd3,
        FWD_W2 = 3'd4
    } fwdSelT;

endpackage

`default_nettype wire

//--- verilog/instDecoder.sv
`include "dualIssue_macros.svh"
`default_nettype none

module instDecoder (
    input  logic [`DATA_W-1:0]     instr_i,
    output dualIssuePkg::aluOpT    aluOp_o,
    output logic                   regWrite_o,
    output logic                   isImm_o,
    output logic                   signExt_o,
    output logic                   readsRs_o,
    output logic                   readsRt_o,
    output logic [`REG_ADDR_W-1:0] writeReg_o
);
    import dualIssuePkg::*;

    localparam int OP_W    = `OP_MSB - `OP_LSB + 1;
    localparam int FUNCT_W = 6;

    localparam logic [OP_W-1:0] OP_SPECIAL = 6'h00;
    localparam logic [OP_W-1:0] OP_ADDIU   = 6'h09;
    localparam logic [OP_W-1:0] OP_ORI     = 6'h0d;
    localparam logic [OP_W-1:0] OP_LUI     = 6'h0f;

    localparam logic [FUNCT_W-1:0] FN_ADDU = 6'h21;
    localparam logic [FUNCT_W-1:0] FN_SUBU = 6'h23;
    localparam logic [FUNCT_W-1:0] FN_AND  = 6'h24;
    localparam logic [FUNCT_W-1:0] FN_OR   = 6'h25;
    localparam logic [FUNCT_W-1:0] FN_XOR  = 6'h26;
    localparam logic [FUNCT_W-1:0] FN_SLT  = 6'h2a;

    logic [OP_W-1:0]        opcode;
    logic [FUNCT_W-1:0]     funct;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   knownFn;

    assign opcode = instr_i[`OP_MSB:`OP_LSB];
    assign funct  = instr_i[FUNCT_W-1:0];
    assign rt     = instr_i[`RT_MSB:`RT_LSB];
    assign rd     = instr_i[`RD_MSB:`RD_LSB];

    always_comb begin
        // anything not listed falls out as a bubble
        aluOp_o    = ALU_ADD;
        regWrite_o = 1'b0;
        isImm_o    = 1'b0;
        signExt_o  = 1'b0;
        readsRs_o  = 1'b0;
        readsRt_o  = 1'b0;
        writeReg_o = '0;
        knownFn    = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                knownFn = 1'b1;
                case (funct)
                    FN_ADDU: aluOp_o = ALU_ADD;
                    FN_SUBU: aluOp_o = ALU_SUB;
                    FN_AND:  aluOp_o = ALU_AND;
                    FN_OR:   aluOp_o = ALU_OR;
                    FN_XOR:  aluOp_o = ALU_XOR;
                    FN_SLT:  aluOp_o = ALU_SLT;
                    default: knownFn = 1'b0;  // sll 0 etc, nop
                endcase
                regWrite_o = knownFn;
                readsRs_o  = knownFn;
                readsRt_o  = knownFn;
                writeReg_o = knownFn ? rd : '0;
            end
            OP_ADDIU: begin
                aluOp_o    = ALU_ADD;
                regWrite_o = 1'b1;
                isImm_o    = 1'b1;
                signExt_o  = 1'b1;
                readsRs_o  = 1'b1;
                writeReg_o = rt;
            end
            OP_ORI: begin
                aluOp_o    = ALU_OR;  // zero-extended immediate
                regWrite_o = 1'b1;
                isImm_o    = 1'b1;
                readsRs_o  = 1'b1;
                writeReg_o = rt;
            end
            OP_LUI: begin
                aluOp_o    = ALU_LUI;
                regWrite_o = 1'b1;
                isImm_o    = 1'b1;
                writeReg_o = rt;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/regFile.sv
`include "dualIssue_macros.svh"
`default_nettype none

module regFile (
    input  logic                   clk,
    input  logic                   rstN_i,
    input  logic                   we1_i,
    input  logic                   we2_i,
    input  logic [`REG_ADDR_W-1:0] waddr1_i,
    input  logic [`REG_ADDR_W-1:0] waddr2_i,
    input  logic [`DATA_W-1:0]     wdata1_i,
    input  logic [`DATA_W-1:0]     wdata2_i,
    input  logic [`REG_ADDR_W-1:0] raddr1a_i,
    input  logic [`REG_ADDR_W-1:0] raddr1b_i,
    input  logic [`REG_ADDR_W-1:0] raddr2a_i,
    input  logic [`REG_ADDR_W-1:0] raddr2b_i,
    output logic [`DATA_W-1:0]     rdata1a_o,
    output logic [`DATA_W-1:0]     rdata1b_o,
    output logic [`DATA_W-1:0]     rdata2a_o,
    output logic [`DATA_W-1:0]     rdata2b_o
);

    localparam int NUM_REGS = 1 << `REG_ADDR_W;

    logic [`DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we1_i) regs[waddr1_i] <= wdata1_i;
            // slave is younger, so on a clash its value stays
            if (we2_i) regs[waddr2_i] <= wdata2_i;
        end
    end

    // $zero is hardwired, whatever was written to it
    assign rdata1a_o = (raddr1a_i == '0) ? '0 : regs[raddr1a_i];
    assign rdata1b_o = (raddr1b_i == '0) ? '0 : regs[raddr1b_i];
    assign rdata2a_o = (raddr2a_i == '0) ? '0 : regs[raddr2a_i];
    assign rdata2b_o = (raddr2b_i == '0) ? '0 : regs[raddr2b_i];

endmodule

`default_nettype wire

//--- verilog/issueControl.sv
`include "dualIssue_macros.svh"
`default_nettype none

module issueControl (
    input  logic                   clk,
    input  logic                   rstN_i,
    input  logic                   iCacheStall_i,
    input  logic                   regWrite1D_i,
    input  logic                   regWrite2D_i,
    input  logic [`REG_ADDR_W-1:0] writeReg1D_i,
    input  logic [`REG_ADDR_W-1:0] writeReg2D_i,
    input  logic [`REG_ADDR_W-1:0] rs1D_i,
    input  logic [`REG_ADDR_W-1:0] rt1D_i,
    input  logic [`REG_ADDR_W-1:0] rs2D_i,
    input  logic [`REG_ADDR_W-1:0] rt2D_i,
    input  logic                   readsRs1D_i,
    input  logic                   readsRt1D_i,
    input  logic                   readsRs2D_i,
    input  logic                   readsRt2D_i,
    input  logic                   regWrite1E_i,
    input  logic [`REG_ADDR_W-1:0] writeReg1E_i,
    input  logic                   regWrite2E_i,
    input  logic [`REG_ADDR_W-1:0] writeReg2E_i,
    input  logic                   regWrite1W_i,
    input  logic [`REG_ADDR_W-1:0] writeReg1W_i,
    input  logic                   regWrite2W_i,
    input  logic [`REG_ADDR_W-1:0] writeReg2W_i,
    output logic                   holdFront_o,
    output logic                   killMasterD_o,
    output logic                   killSlaveD_o,
    output dualIssuePkg::fwdSelT   fwd1a_o,
    output dualIssuePkg::fwdSelT   fwd1b_o,
    output dualIssuePkg::fwdSelT   fwd2a_o,
    output dualIssuePkg::fwdSelT   fwd2b_o
);
    import dualIssuePkg::*;

    logic splitQ;   // master of a split pair already issued
    logic rawDep;
    logic wawDep;

    // youngest writer first, lane 2 is younger than lane 1 of the same stage
    function automatic fwdSelT pickFwd(input logic reads, input logic [`REG_ADDR_W-1:0] src);
        if (!reads || src == '0) return FWD_RF;
        if (regWrite2E_i && writeReg2E_i == src) return FWD_E2;
        if (regWrite1E_i && writeReg1E_i == src) return FWD_E1;
        if (regWrite2W_i && writeReg2W_i == src) return FWD_W2;
        if (regWrite1W_i && writeReg1W_i == src) return FWD_W1;
        return FWD_RF;
    endfunction

    // slave needs the master's result, which does not exist yet
    assign rawDep = regWrite1D_i && (writeReg1D_i != '0) &&
                    ((readsRs2D_i && rs2D_i == writeReg1D_i) ||
                     (readsRt2D_i && rt2D_i == writeReg1D_i));

    // same destination in both lanes, retire them one per cycle
    assign wawDep = regWrite1D_i && regWrite2D_i && (writeReg1D_i != '0) &&
                    (writeReg2D_i == writeReg1D_i);

    // first cycle: master alone, front waits
    assign holdFront_o   = (rawDep || wawDep) && !splitQ;
    assign killSlaveD_o  = holdFront_o;
    // second cycle: master already gone, slave follows
    assign killMasterD_o = splitQ;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            splitQ <= 1'b0;
        end else if (!iCacheStall_i) begin
            splitQ <= holdFront_o;  // clears on the following advance
        end
    end

    always_comb begin
        fwd1a_o = pickFwd(readsRs1D_i, rs1D_i);
        fwd1b_o = pickFwd(readsRt1D_i, rt1D_i);
        fwd2a_o = pickFwd(readsRs2D_i, rs2D_i);
        fwd2b_o = pickFwd(readsRt2D_i, rt2D_i);
    end

endmodule

`default_nettype wire

//--- verilog/aluUnit.sv
`include "dualIssue_macros.svh"
`default_nettype none

module aluUnit (
    input  dualIssuePkg::aluOpT    aluOp_i,
    input  logic [`DATA_W-1:0]     srcA_i,
    input  logic [`DATA_W-1:0]     srcB_i,
    output logic [`DATA_W-1:0]     result_o
);
    import dualIssuePkg::*;

    logic lessThan;

    assign lessThan = $signed(srcA_i) < $signed(srcB_i);

    always_comb begin
        case (aluOp_i)
            ALU_ADD: result_o = srcA_i + srcB_i;  // addu/addiu, no overflow trap
            ALU_SUB: result_o = srcA_i - srcB_i;
            ALU_AND: result_o = srcA_i & srcB_i;
            ALU_OR:  result_o = srcA_i | srcB_i;
            ALU_XOR: result_o = srcA_i ^ srcB_i;
            ALU_SLT: result_o = {{(`DATA_W-1){1'b0}}, lessThan};
            // immediate arrives zero-extended on srcB
            ALU_LUI: result_o = srcB_i << `IMM_W;
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/datapath.sv
`include "dualIssue_macros.svh"
`default_nettype none

module datapath (
    input  logic                   clk,
    input  logic                   rstN_i,
    input  logic                   iCacheStall_i,
    input  logic [`DATA_W-1:0]     inst1F2_i,
    input  logic [`DATA_W-1:0]     inst2F2_i,
    output logic [`DATA_W-1:0]     pcIf1_o,
    output logic                   instEnF_o,
    output logic [`DATA_W-1:0]     debugWbPc1_o,
    output logic [3:0]             debugWbWen1_o,
    output logic [`REG_ADDR_W-1:0] debugWbWnum1_o,
    output logic [`DATA_W-1:0]     debugWbWdata1_o,
    output logic [`DATA_W-1:0]     debugWbPc2_o,
    output logic [3:0]             debugWbWen2_o,
    output logic [`REG_ADDR_W-1:0] debugWbWnum2_o,
    output logic [`DATA_W-1:0]     debugWbWdata2_o
);
    import dualIssuePkg::*;

    localparam logic [`DATA_W-1:0] WORD_STEP = `FETCH_STEP / 2;

    logic                   advance;  // no icache stall, everything moves
    logic                   holdFront, killMasterD, killSlaveD;
    logic                   validF2;
    logic [`DATA_W-1:0]     pcF2;
    logic [`DATA_W-1:0]     instr1D, instr2D, pcD;
    aluOpT                  aluOp1D, aluOp2D;
    logic                   regWrite1D, regWrite2D, isImm1D, isImm2D;
    logic                   signExt1D, signExt2D;
    logic                   readsRs1D, readsRt1D, readsRs2D, readsRt2D;
    logic [`REG_ADDR_W-1:0] writeReg1D, writeReg2D;
    logic [`DATA_W-1:0]     rdata1a, rdata1b, rdata2a, rdata2b;
    fwdSelT                 fwd1a, fwd1b, fwd2a, fwd2b;
    logic [`DATA_W-1:0]     src1aD, src1bD, src2aD, src2bD;
    logic [`DATA_W-1:0]     opB1D, opB2D;
    logic                   regWrite1E, regWrite2E;
    logic [`REG_ADDR_W-1:0] writeReg1E, writeReg2E;
    aluOpT                  aluOp1E, aluOp2E;
    logic [`DATA_W-1:0]     srcA1E, srcB1E, srcA2E, srcB2E, pc1E, pc2E;
    logic [`DATA_W-1:0]     aluOut1E, aluOut2E;
    logic                   regWrite1W, regWrite2W, rfWe1, rfWe2;
    logic [`REG_ADDR_W-1:0] writeReg1W, writeReg2W;
    logic [`DATA_W-1:0]     result1W, result2W, pc1W, pc2W;

    function automatic logic [`DATA_W-1:0] pickSrc(
        input fwdSelT             sel,
        input logic [`DATA_W-1:0] rfVal,
        input logic [`DATA_W-1:0] e1Val,
        input logic [`DATA_W-1:0] e2Val,
        input logic [`DATA_W-1:0] w1Val,
        input logic [`DATA_W-1:0] w2Val
    );
        case (sel)
            FWD_E1:  return e1Val;
            FWD_E2:  return e2Val;
            FWD_W1:  return w1Val;
            FWD_W2:  return w2Val;
            default: return rfVal;
        endcase
    endfunction

    function automatic logic [`DATA_W-1:0] extImm(
        input logic [`DATA_W-1:0] instr,
        input logic               signExt
    );
        return {{(`DATA_W-`IMM_W){signExt & instr[`IMM_W-1]}}, instr[`IMM_W-1:0]};
    endfunction

    assign advance   = ~iCacheStall_i;
    assign instEnF_o = advance & ~holdFront;  // front moves only when D can take a pair

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            pcIf1_o <= `RESET_PC;
            validF2 <= 1'b0;
            instr1D <= '0;
            instr2D <= '0;
        end else if (instEnF_o) begin
            pcIf1_o <= pcIf1_o + `DATA_W'(`FETCH_STEP);
            validF2 <= 1'b1;
            instr1D <= validF2 ? inst1F2_i : '0;  // nothing fetched yet, bubble
            instr2D <= validF2 ? inst2F2_i : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (instEnF_o) begin
            pcF2 <= pcIf1_o;
            pcD  <= pcF2;
        end
    end

    instDecoder u_dec1 (.instr_i(instr1D), .aluOp_o(aluOp1D), .regWrite_o(regWrite1D),
        .isImm_o(isImm1D), .signExt_o(signExt1D), .readsRs_o(readsRs1D),
        .readsRt_o(readsRt1D), .writeReg_o(writeReg1D));
    instDecoder u_dec2 (.instr_i(instr2D), .aluOp_o(aluOp2D), .regWrite_o(regWrite2D),
        .isImm_o(isImm2D), .signExt_o(signExt2D), .readsRs_o(readsRs2D),
        .readsRt_o(readsRt2D), .writeReg_o(writeReg2D));

    regFile u_rf (.clk(clk), .rstN_i(rstN_i), .we1_i(rfWe1), .we2_i(rfWe2),
        .waddr1_i(writeReg1W), .waddr2_i(writeReg2W), .wdata1_i(result1W), .wdata2_i(result2W),
        .raddr1a_i(instr1D[`RS_MSB:`RS_LSB]), .raddr1b_i(instr1D[`RT_MSB:`RT_LSB]),
        .raddr2a_i(instr2D[`RS_MSB:`RS_LSB]), .raddr2b_i(instr2D[`RT_MSB:`RT_LSB]),
        .rdata1a_o(rdata1a), .rdata1b_o(rdata1b), .rdata2a_o(rdata2a), .rdata2b_o(rdata2b));

    issueControl u_issue (.clk(clk), .rstN_i(rstN_i), .iCacheStall_i(iCacheStall_i),
        .regWrite1D_i(regWrite1D), .regWrite2D_i(regWrite2D),
        .writeReg1D_i(writeReg1D), .writeReg2D_i(writeReg2D),
        .rs1D_i(instr1D[`RS_MSB:`RS_LSB]), .rt1D_i(instr1D[`RT_MSB:`RT_LSB]),
        .rs2D_i(instr2D[`RS_MSB:`RS_LSB]), .rt2D_i(instr2D[`RT_MSB:`RT_LSB]),
        .readsRs1D_i(readsRs1D), .readsRt1D_i(readsRt1D),
        .readsRs2D_i(readsRs2D), .readsRt2D_i(readsRt2D),
        .regWrite1E_i(regWrite1E), .writeReg1E_i(writeReg1E),
        .regWrite2E_i(regWrite2E), .writeReg2E_i(writeReg2E),
        .regWrite1W_i(regWrite1W), .writeReg1W_i(writeReg1W),
        .regWrite2W_i(regWrite2W), .writeReg2W_i(writeReg2W),
        .holdFront_o(holdFront), .killMasterD_o(killMasterD), .killSlaveD_o(killSlaveD),
        .fwd1a_o(fwd1a), .fwd1b_o(fwd1b), .fwd2a_o(fwd2a), .fwd2b_o(fwd2b));

    // operand values at decode
    assign src1aD = pickSrc(fwd1a, rdata1a, aluOut1E, aluOut2E, result1W, result2W);
    assign src1bD = pickSrc(fwd1b, rdata1b, aluOut1E, aluOut2E, result1W, result2W);
    assign src2aD = pickSrc(fwd2a, rdata2a, aluOut1E, aluOut2E, result1W, result2W);
    assign src2bD = pickSrc(fwd2b, rdata2b, aluOut1E, aluOut2E, result1W, result2W);
    assign opB1D  = isImm1D ? extImm(instr1D, signExt1D) : src1bD;
    assign opB2D  = isImm2D ? extImm(instr2D, signExt2D) : src2bD;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            regWrite1E <= 1'b0;
            regWrite2E <= 1'b0;
            regWrite1W <= 1'b0;
            regWrite2W <= 1'b0;
        end else if (advance) begin
            regWrite1E <= regWrite1D & ~killMasterD;  // split kills become bubbles
            regWrite2E <= regWrite2D & ~killSlaveD;
            regWrite1W <= regWrite1E;
            regWrite2W <= regWrite2E;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            writeReg1E <= writeReg1D;
            writeReg2E <= writeReg2D;
            aluOp1E    <= aluOp1D;
            aluOp2E    <= aluOp2D;
            srcA1E     <= src1aD;
            srcB1E     <= opB1D;
            srcA2E     <= src2aD;
            srcB2E     <= opB2D;
            pc1E       <= pcD;
            pc2E       <= pcD + WORD_STEP;  // slave word sits after the master
            writeReg1W <= writeReg1E;
            writeReg2W <= writeReg2E;
            result1W   <= aluOut1E;
            result2W   <= aluOut2E;
            pc1W       <= pc1E;
            pc2W       <= pc2E;
        end
    end

    aluUnit u_alu1 (.aluOp_i(aluOp1E), .srcA_i(srcA1E), .srcB_i(srcB1E), .result_o(aluOut1E));
    aluUnit u_alu2 (.aluOp_i(aluOp2E), .srcA_i(srcA2E), .srcB_i(srcB2E), .result_o(aluOut2E));

    // a frozen W stage neither writes nor shows up on the trace
    assign rfWe1 = regWrite1W & advance;
    assign rfWe2 = regWrite2W & advance;

    assign debugWbPc1_o    = pc1W;
    assign debugWbWen1_o   = {4{rfWe1}};
    assign debugWbWnum1_o  = writeReg1W;
    assign debugWbWdata1_o = result1W;
    assign debugWbPc2_o    = pc2W;
    assign debugWbWen2_o   = {4{rfWe2}};
    assign debugWbWnum2_o  = writeReg2W;
    assign debugWbWdata2_o = result2W;

endmodule

`default_nettype wire

//--- tests/tb_datapath.sv
`include "dualIssue_macros.svh"
`default_nettype none

module tb_datapath;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_LEN       = 240;
    localparam int TIMEOUT_CYCLES = 5000;
    localparam int TAIL_CYCLES    = 20;  // nops after the program, nothing may retire

    // encodings, kept separate from the decoder
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_XOR     = 6'h26;
    localparam logic [5:0] FN_SLT     = 6'h2a;

    logic                   clk;
    logic                   rstN_i;
    logic                   iCacheStall_i;
    logic [`DATA_W-1:0]     inst1F2_i;
    logic [`DATA_W-1:0]     inst2F2_i;
    logic [`DATA_W-1:0]     pcIf1_o;
    logic                   instEnF_o;
    logic [`DATA_W-1:0]     debugWbPc1_o;
    logic [3:0]             debugWbWen1_o;
    logic [`REG_ADDR_W-1:0] debugWbWnum1_o;
    logic [`DATA_W-1:0]     debugWbWdata1_o;
    logic [`DATA_W-1:0]     debugWbPc2_o;
    logic [3:0]             debugWbWen2_o;
    logic [`REG_ADDR_W-1:0] debugWbWnum2_o;
    logic [`DATA_W-1:0]     debugWbWdata2_o;

    integer                 seed;
    logic [`DATA_W-1:0]     prog [$];
    logic [`DATA_W-1:0]     modelRegs [32];
    logic [`DATA_W-1:0]     expPc [$];       // expected trace, oldest first
    logic [`REG_ADDR_W-1:0] expNum [$];
    logic [`DATA_W-1:0]     expData [$];
    logic [`DATA_W-1:0]     fetchPc;
    logic                   fetchPending;    // words owed on the next falling edge
    int                     checks;
    int                     valueErrors;
    int                     otherErrors;
    int                     cycles;

    datapath dut (
        .clk(clk), .rstN_i(rstN_i), .iCacheStall_i(iCacheStall_i),
        .inst1F2_i(inst1F2_i), .inst2F2_i(inst2F2_i),
        .pcIf1_o(pcIf1_o), .instEnF_o(instEnF_o),
        .debugWbPc1_o(debugWbPc1_o), .debugWbWen1_o(debugWbWen1_o),
        .debugWbWnum1_o(debugWbWnum1_o), .debugWbWdata1_o(debugWbWdata1_o),
        .debugWbPc2_o(debugWbPc2_o), .debugWbWen2_o(debugWbWen2_o),
        .debugWbWnum2_o(debugWbWnum2_o), .debugWbWdata2_o(debugWbWdata2_o)
    );

    always #10 clk = ~clk;

    task automatic checkPc(input string name, input logic [`DATA_W-1:0] got,
                           input logic [`DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            valueErrors++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkReg(input string name, input logic [`REG_ADDR_W-1:0] got,
                            input logic [`REG_ADDR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            valueErrors++;
            $display("Error at %0d ns: %s is r%0d, expected r%0d", $time, name, got, exp);
        end
    endtask

    task automatic checkData(input string name, input logic [`DATA_W-1:0] got,
                             input logic [`DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            valueErrors++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkWen(input string name, input logic [3:0] got, input logic [3:0] exp);
        checks++;
        if (got !== exp) begin
            valueErrors++;
            $display("Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            valueErrors++;
            $display("Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    function automatic logic [`DATA_W-1:0] encodeR(input logic [5:0] funct,
            input logic [`REG_ADDR_W-1:0] rs, input logic [`REG_ADDR_W-1:0] rt,
            input logic [`REG_ADDR_W-1:0] rd);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [`DATA_W-1:0] encodeI(input logic [5:0] op,
            input logic [`REG_ADDR_W-1:0] rs, input logic [`REG_ADDR_W-1:0] rt,
            input logic [`IMM_W-1:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // instruction memory, nops outside the program
    function automatic logic [`DATA_W-1:0] memWord(input logic [`DATA_W-1:0] addr);
        logic [`DATA_W-1:0] offset;
        int idx;
        offset = addr - `RESET_PC;
        idx = int'(offset >> 2);
        if (addr < `RESET_PC || idx < 0 || idx >= PROG_LEN) return '0;
        return prog[idx];
    endfunction

    task automatic buildProgram();
        logic [`DATA_W-1:0] r;
        logic [`DATA_W-1:0] r2;
        logic [`REG_ADDR_W-1:0] rs, rt, rd;
        int kind;
        for (int i = 0; i < PROG_LEN; i++) begin
            r = $random(seed);
            r2 = $random(seed);
            kind = int'(r % 9);
            rs = {2'b00, r2[18:16]};  // r0..r7 only, dense dependencies
            rt = {2'b00, r2[21:19]};
            rd = {2'b00, r2[24:22]};
            case (kind)
                0: prog.push_back(encodeR(FN_ADDU, rs, rt, rd));
                1: prog.push_back(encodeR(FN_SUBU, rs, rt, rd));
                2: prog.push_back(encodeR(FN_AND, rs, rt, rd));
                3: prog.push_back(encodeR(FN_OR, rs, rt, rd));
                4: prog.push_back(encodeR(FN_XOR, rs, rt, rd));
                5: prog.push_back(encodeR(FN_SLT, rs, rt, rd));
                6: prog.push_back(encodeI(OP_ADDIU, rs, rt, r2[`IMM_W-1:0]));
                7: prog.push_back(encodeI(OP_ORI, rs, rt, r2[`IMM_W-1:0]));
                default: prog.push_back(encodeI(OP_LUI, 5'd0, rt, r2[`IMM_W-1:0]));
            endcase
        end
    endtask

    // sequential mips semantics, one queue entry per register write
    task automatic runModel();
        logic [`DATA_W-1:0] w, a, b, res, immS, immZ;
        logic [`REG_ADDR_W-1:0] dest;
        logic writes;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            w = prog[i];
            a = modelRegs[w[`RS_MSB:`RS_LSB]];
            b = modelRegs[w[`RT_MSB:`RT_LSB]];
            immS = {{(`DATA_W-`IMM_W){w[`IMM_W-1]}}, w[`IMM_W-1:0]};
            immZ = {{(`DATA_W-`IMM_W){1'b0}}, w[`IMM_W-1:0]};
            dest = w[`RT_MSB:`RT_LSB];  // i-type target
            res = '0;
            writes = 1'b1;
            case (w[`OP_MSB:`OP_LSB])
                OP_SPECIAL: begin
                    dest = w[`RD_MSB:`RD_LSB];
                    case (w[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: writes = 1'b0;
                    endcase
                end
                OP_ADDIU: res = a + immS;
                OP_ORI:   res = a | immZ;
                OP_LUI:   res = {w[`IMM_W-1:0], {`IMM_W{1'b0}}};
                default:  writes = 1'b0;
            endcase
            if (writes) begin
                expPc.push_back(`RESET_PC + 32'(4 * i));
                expNum.push_back(dest);
                expData.push_back(res);
                if (dest != '0) modelRegs[dest] = res;  // r0 write shows on the trace only
            end
        end
    endtask

    task automatic retireLane(input int lane, input logic [3:0] wen,
            input logic [`DATA_W-1:0] pc, input logic [`REG_ADDR_W-1:0] wnum,
            input logic [`DATA_W-1:0] wdata);
        string sfx;
        sfx = $sformatf("%0d_o", lane);
        checkWen({"debugWbWen", sfx}, wen, 4'hf);
        if (expPc.size() == 0) begin
            otherErrors++;
            $display("Error at %0d ns: lane %0d wrote r%0d but the model has no write left",
                     $time, lane, wnum);
        end else begin
            checkPc({"debugWbPc", sfx}, pc, expPc.pop_front());
            checkReg({"debugWbWnum", sfx}, wnum, expNum.pop_front());
            checkData({"debugWbWdata", sfx}, wdata, expData.pop_front());
        end
    endtask

    task automatic traceCycle();
        // lane 1 is older within a cycle
        if (debugWbWen1_o != 4'h0) begin
            retireLane(1, debugWbWen1_o, debugWbPc1_o, debugWbWnum1_o, debugWbWdata1_o);
        end
        if (debugWbWen2_o != 4'h0) begin
            retireLane(2, debugWbWen2_o, debugWbPc2_o, debugWbWnum2_o, debugWbWdata2_o);
        end
    endtask

    task automatic captureFetch();
        if (instEnF_o) begin
            fetchPc = pcIf1_o;  // taken at the coming rising edge
            fetchPending = 1'b1;
        end
    endtask

    task automatic driveInputs();
        logic [`DATA_W-1:0] r;
        if (fetchPending) begin
            inst1F2_i = memWord(fetchPc);
            inst2F2_i = memWord(fetchPc + 32'd4);
            fetchPending = 1'b0;
        end
        r = $random(seed);
        iCacheStall_i = (r[1:0] == 2'b00);  // about one cycle in four
    endtask

    task automatic stepCycle();
        @(negedge clk);
        driveInputs();
        #5;  // mid low phase, outputs settled
        traceCycle();
        captureFetch();
    endtask

    initial begin
        clk = 1'b0;
        rstN_i = 1'b0;
        iCacheStall_i = 1'b0;
        inst1F2_i = '0;
        inst2F2_i = '0;
        seed = 32'h61e6;
        fetchPc = '0;
        fetchPending = 1'b0;
        checks = 0;
        valueErrors = 0;
        otherErrors = 0;
        buildProgram();
        runModel();

        repeat (4) begin
            @(posedge clk);
            #5;
            checkWen("debugWbWen1_o", debugWbWen1_o, 4'h0);
            checkWen("debugWbWen2_o", debugWbWen2_o, 4'h0);
            checkPc("pcIf1_o", pcIf1_o, `RESET_PC);
        end
        @(negedge clk);
        rstN_i = 1'b1;
        #5;
        // first cycle out of reset, no stall
        checkPc("pcIf1_o", pcIf1_o, `RESET_PC);
        checkFlag("instEnF_o", instEnF_o, 1'b1);
        checkWen("debugWbWen1_o", debugWbWen1_o, 4'h0);
        checkWen("debugWbWen2_o", debugWbWen2_o, 4'h0);
        captureFetch();

        cycles = 0;
        while (expPc.size() > 0 && cycles < TIMEOUT_CYCLES) begin
            stepCycle();
            cycles++;
        end
        if (expPc.size() > 0) begin
            otherErrors++;
            $display("Error: timeout, %0d expected writes still missing after %0d cycles",
                     expPc.size(), TIMEOUT_CYCLES);
        end
        repeat (TAIL_CYCLES) begin
            stepCycle();
        end

        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
verilog/dualIssuePkg.sv
verilog/instDecoder.sv
verilog/regFile.sv
verilog/issueControl.sv
verilog/aluUnit.sv
verilog/datapath.sv
tests/tb_datapath.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the dual-issue datapath testbench with verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary -f vlog.f --top-module tb_datapath -o tb_datapath
./obj_dir/tb_datapath | tee "$LOG"

if grep -q "TB PASSED" "$LOG"; then
    exit 0
else
    echo "simulation did not pass, see $LOG"
    exit 1
fi
